//--- Bender.yml
package:
  name: eth_mac_rx

sources:
  - files:
      - eth_rx_pkg.sv
      - gmii_rx_framer.sv
      - mcf_rx_parser.sv
      - lfc_pause_rx.sv
      - eth_mac_rx.sv
  - target: test
    files:
      - eth_mac_rx_checker.sv
      - tb_eth_mac_rx.sv

//--- compile.f
eth_rx_pkg.sv
gmii_rx_framer.sv
mcf_rx_parser.sv
lfc_pause_rx.sv
eth_mac_rx.sv
eth_mac_rx_checker.sv
tb_eth_mac_rx.sv

//--- eth_mac_rx.sv
`timescale 1ns/1ps

module eth_mac_rx (
    input  logic                   rx_clk,
    input  logic                   rx_rst,
    input  eth_rx_pkg::gmii_rx_t   gmii,
    input  logic                   rx_lfc_en,
    output eth_rx_pkg::rx_beat_t   rx_axis,
    output eth_rx_pkg::rx_status_t rx_status,
    output logic                   rx_lfc_req,
    output eth_rx_pkg::lfc_stat_t  stat_rx
);

    eth_rx_pkg::rx_beat_t beat;
    logic                 mcf_valid;
    eth_rx_pkg::mcf_t     mcf;

    gmii_rx_framer framer_i (
        .rx_clk (rx_clk),
        .rx_rst (rx_rst),
        .gmii   (gmii),
        .beat   (beat),
        .status (rx_status)
    );

    // Control frames stay in the stream, the parser only listens.
    assign rx_axis = beat;

    mcf_rx_parser parser_i (
        .rx_clk    (rx_clk),
        .rx_rst    (rx_rst),
        .beat      (beat),
        .mcf_valid (mcf_valid),
        .mcf       (mcf)
    );

    lfc_pause_rx pause_i (
        .rx_clk     (rx_clk),
        .rx_rst     (rx_rst),
        .mcf_valid  (mcf_valid),
        .mcf        (mcf),
        .rx_lfc_en  (rx_lfc_en),
        .rx_lfc_req (rx_lfc_req),
        .stat       (stat_rx)
    );

endmodule

//--- eth_mac_rx_checker.sv
`timescale 1ns/1ps

module eth_mac_rx_checker (
    input logic                   rx_clk,
    input logic                   rx_rst,
    input logic                   rx_lfc_en,
    input eth_rx_pkg::rx_beat_t   rx_axis,
    input eth_rx_pkg::rx_status_t rx_status,
    input logic                   mcf_valid,
    input logic                   rx_lfc_req
);

    int fail_cnt = 0;

    // Error pulses ride on the bad last beat.
    err_on_last: assert property (@(posedge rx_clk) disable iff (rx_rst)
        (rx_status.error_bad_frame || rx_status.error_bad_fcs)
        |-> (rx_axis.valid && rx_axis.last && rx_axis.bad))
    else begin
        fail_cnt++;
        $error("error pulse without a bad last beat");
    end

    mcf_after_good_last: assert property (@(posedge rx_clk) disable iff (rx_rst)
        mcf_valid |-> $past(rx_axis.valid && rx_axis.last && !rx_axis.bad))
    else begin
        fail_cnt++;
        $error("mcf_valid without a good last beat one cycle before");
    end

    // Disabling flow control drops the request on the next clock.
    lfc_off_clears_req: assert property (@(posedge rx_clk) disable iff (rx_rst)
        !rx_lfc_en |=> !rx_lfc_req)
    else begin
        fail_cnt++;
        $error("rx_lfc_req still high after rx_lfc_en went low");
    end

    bad_frame_one_cycle: assert property (@(posedge rx_clk) disable iff (rx_rst)
        rx_status.error_bad_frame |=> !rx_status.error_bad_frame)
    else begin
        fail_cnt++;
        $error("error_bad_frame longer than one cycle");
    end

    bad_fcs_one_cycle: assert property (@(posedge rx_clk) disable iff (rx_rst)
        rx_status.error_bad_fcs |=> !rx_status.error_bad_fcs)
    else begin
        fail_cnt++;
        $error("error_bad_fcs longer than one cycle");
    end

endmodule

//--- eth_rx_pkg.sv
package eth_rx_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] eth_type_t;

    // Framing.
    localparam byte_t ETH_PREAMBLE_BYTE   = 8'h55;
    localparam byte_t ETH_SFD_BYTE        = 8'hD5;
    localparam int    ETH_FCS_BYTES       = 4;
    localparam int    ETH_MIN_FRAME_BYTES = 64;
    localparam int    FRAME_CNT_W         = $clog2(ETH_MIN_FRAME_BYTES + 1);

    // Reflected CRC-32.
    localparam logic [31:0] CRC_POLY    = 32'hEDB88320;
    localparam logic [31:0] CRC_INIT    = 32'hFFFFFFFF;
    // Register value once a good FCS has been shifted through.
    localparam logic [31:0] CRC_RESIDUE = 32'hDEBB20E3;

    // MAC control frames.
    localparam mac_addr_t MCF_DST_ADDR  = 48'h0180C2000001;
    localparam eth_type_t MCF_ETH_TYPE  = 16'h8808;
    localparam eth_type_t LFC_OPCODE    = 16'h0001;
    localparam int        MCF_HDR_BYTES = 18;
    localparam int        HDR_IDX_W     = $clog2(MCF_HDR_BYTES + 1);

    // One quantum is 512 bit times, 64 byte clocks at 1 Gb/s.
    localparam int                        QUANTA_COUNT_W = 22;
    localparam logic [QUANTA_COUNT_W-1:0] QUANTUM_CYCLES = 64;

    typedef struct packed {
        byte_t rxd;
        logic  dv;
        logic  er;
    } gmii_rx_t;

    typedef struct packed {
        logic  valid;
        byte_t data;
        logic  last;
        logic  bad;
    } rx_beat_t;

    typedef struct packed {
        logic start_packet;
        logic error_bad_frame;
        logic error_bad_fcs;
    } rx_status_t;

    typedef struct packed {
        mac_addr_t   eth_dst;
        mac_addr_t   eth_src;
        eth_type_t   eth_type;
        eth_type_t   opcode;
        logic [15:0] quanta;
    } mcf_t;

    typedef struct packed {
        logic pkt;
        logic xon;
        logic xoff;
        logic paused;
    } lfc_stat_t;

    // One byte of CRC-32, LSB first.
    function automatic logic [31:0] crc32_byte(logic [31:0] crc, byte_t data);
        logic [31:0] c;
        c = crc ^ {24'h000000, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

endpackage

//--- gmii_rx_framer.sv
`timescale 1ns/1ps

module gmii_rx_framer (
    input  logic                   rx_clk,
    input  logic                   rx_rst,
    input  eth_rx_pkg::gmii_rx_t   gmii,
    output eth_rx_pkg::rx_beat_t   beat,
    output eth_rx_pkg::rx_status_t status
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_FRAME
    } state_t;

    state_t                                        state;
    eth_rx_pkg::gmii_rx_t                          gmii_q;
    eth_rx_pkg::byte_t [eth_rx_pkg::ETH_FCS_BYTES-1:0] fcs_sr;
    logic [eth_rx_pkg::FRAME_CNT_W-1:0]            byte_cnt;
    logic                                          er_seen;
    logic [31:0]                                   crc;

    logic [31:0]                                   crc_next;
    logic [eth_rx_pkg::FRAME_CNT_W-1:0]            cnt_next;
    logic                                          er_next;
    logic                                          frame_end;
    logic                                          runt;
    logic                                          fcs_bad;
    logic                                          frame_err;
    logic                                          line_full;

    // The FSM works on the registered byte, the live dv gives one byte of lookahead.
    always_comb begin
        crc_next  = eth_rx_pkg::crc32_byte(crc, gmii_q.rxd);
        if (byte_cnt == eth_rx_pkg::ETH_MIN_FRAME_BYTES) begin
            cnt_next = byte_cnt;
        end else begin
            cnt_next = byte_cnt + 1'b1;
        end
        er_next   = er_seen | gmii_q.er;
        frame_end = !gmii.dv;
        runt      = cnt_next < eth_rx_pkg::ETH_MIN_FRAME_BYTES;
        fcs_bad   = crc_next != eth_rx_pkg::CRC_RESIDUE;
        frame_err = er_next | runt;
        // Four bytes already held back, so the oldest one is payload.
        line_full = byte_cnt >= eth_rx_pkg::ETH_FCS_BYTES;
    end

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            state    <= ST_IDLE;
            gmii_q   <= '0;
            byte_cnt <= '0;
            er_seen  <= 1'b0;
            beat     <= '0;
            status   <= '0;
        end else begin
            gmii_q     <= gmii;
            beat.valid <= 1'b0;
            beat.last  <= 1'b0;
            beat.bad   <= 1'b0;
            status     <= '0;

            case (state)
                ST_IDLE: begin
                    // Wait for a gap before hunting for the next preamble.
                    if (!gmii_q.dv) begin
                        state <= ST_PREAMBLE;
                    end
                end

                ST_PREAMBLE: begin
                    if (gmii_q.dv) begin
                        if (gmii_q.rxd == eth_rx_pkg::ETH_SFD_BYTE && gmii.dv) begin
                            state               <= ST_FRAME;
                            status.start_packet <= 1'b1;
                            byte_cnt            <= '0;
                            er_seen             <= 1'b0;
                        end else if (gmii_q.rxd != eth_rx_pkg::ETH_PREAMBLE_BYTE) begin
                            state <= ST_IDLE;
                        end
                    end
                end

                ST_FRAME: begin
                    byte_cnt <= cnt_next;
                    er_seen  <= er_next;
                    if (line_full) begin
                        beat.valid <= 1'b1;
                        beat.data  <= fcs_sr[eth_rx_pkg::ETH_FCS_BYTES-1];
                        beat.last  <= frame_end;
                        beat.bad   <= frame_end & (frame_err | fcs_bad);
                        status.error_bad_frame <= frame_end & frame_err;
                        status.error_bad_fcs   <= frame_end & !frame_err & fcs_bad;
                    end
                    if (frame_end) begin
                        state <= ST_IDLE;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // CRC and the FCS delay line.
    always_ff @(posedge rx_clk) begin
        if (state == ST_PREAMBLE) begin
            crc <= eth_rx_pkg::CRC_INIT;
        end else if (state == ST_FRAME) begin
            crc    <= crc_next;
            fcs_sr <= {fcs_sr[eth_rx_pkg::ETH_FCS_BYTES-2:0], gmii_q.rxd};
        end
    end

endmodule

//--- lfc_pause_rx.sv
`timescale 1ns/1ps

module lfc_pause_rx (
    input  logic                  rx_clk,
    input  logic                  rx_rst,
    input  logic                  mcf_valid,
    input  eth_rx_pkg::mcf_t      mcf,
    input  logic                  rx_lfc_en,
    output logic                  rx_lfc_req,
    output eth_rx_pkg::lfc_stat_t stat
);

    localparam int CNT_W = eth_rx_pkg::QUANTA_COUNT_W;

    logic [CNT_W-1:0] pause_cnt;
    logic [CNT_W-1:0] quanta_ext;
    logic [CNT_W-1:0] load_val;
    logic             stat_pkt;
    logic             stat_xon;
    logic             stat_xoff;

    assign quanta_ext = {{(CNT_W - 16){1'b0}}, mcf.quanta};
    assign load_val   = quanta_ext * eth_rx_pkg::QUANTUM_CYCLES;

    // Paused for as long as the count is nonzero.
    assign rx_lfc_req = pause_cnt != '0;

    always_comb begin
        stat.pkt    = stat_pkt;
        stat.xon    = stat_xon;
        stat.xoff   = stat_xoff;
        stat.paused = rx_lfc_req;
    end

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            pause_cnt <= '0;
            stat_pkt  <= 1'b0;
            stat_xon  <= 1'b0;
            stat_xoff <= 1'b0;
        end else begin
            stat_pkt  <= 1'b0;
            stat_xon  <= 1'b0;
            stat_xoff <= 1'b0;

            if (!rx_lfc_en) begin
                // Flow control disabled, drop any pause in progress.
                pause_cnt <= '0;
            end else if (mcf_valid) begin
                stat_pkt <= 1'b1;
                if (mcf.quanta != 16'h0000) begin
                    pause_cnt <= load_val;
                    stat_xoff <= 1'b1;
                end else begin
                    pause_cnt <= '0;
                    stat_xon  <= 1'b1;
                end
            end else if (rx_lfc_req) begin
                pause_cnt <= pause_cnt - 1'b1;
            end
        end
    end

endmodule

//--- mcf_rx_parser.sv
`timescale 1ns/1ps

module mcf_rx_parser (
    input  logic                 rx_clk,
    input  logic                 rx_rst,
    input  eth_rx_pkg::rx_beat_t beat,
    output logic                 mcf_valid,
    output eth_rx_pkg::mcf_t     mcf
);

    localparam int MCF_BITS = $bits(eth_rx_pkg::mcf_t);

    logic [eth_rx_pkg::HDR_IDX_W-1:0] idx;
    eth_rx_pkg::mcf_t                 hdr;
    logic                             hdr_done;
    logic                             is_pause;

    // All 18 header bytes collected before the current beat.
    assign hdr_done = idx == eth_rx_pkg::MCF_HDR_BYTES;

    assign is_pause = hdr_done
                    && hdr.eth_dst  == eth_rx_pkg::MCF_DST_ADDR
                    && hdr.eth_type == eth_rx_pkg::MCF_ETH_TYPE
                    && hdr.opcode   == eth_rx_pkg::LFC_OPCODE;

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            idx       <= '0;
            mcf_valid <= 1'b0;
        end else begin
            mcf_valid <= 1'b0;
            if (beat.valid) begin
                if (beat.last) begin
                    idx <= '0;
                end else if (!hdr_done) begin
                    idx <= idx + 1'b1;
                end
                // Bad frames never trigger a pause.
                mcf_valid <= beat.last && !beat.bad && is_pause;
            end
        end
    end

    // Bytes arrive in header order, so shifting in from the right leaves
    // dst, src, type, opcode and quanta in their struct fields.
    always_ff @(posedge rx_clk) begin
        if (beat.valid && !hdr_done) begin
            hdr <= eth_rx_pkg::mcf_t'({hdr[MCF_BITS-9:0], beat.data});
        end
        if (beat.valid && beat.last) begin
            mcf <= hdr;
        end
    end

endmodule

//--- tb_eth_mac_rx.sv
`timescale 1ns/1ps

module tb_eth_mac_rx;

    localparam int CLK_PERIOD = 4;
    localparam int QUANTUM    = 64;

    typedef enum int {KIND_DATA, KIND_PAUSE} kind_t;
    // Shape of rx_lfc_req around the end of the frame.
    typedef enum int {REQ_LOW, REQ_PULSE, REQ_RISE, REQ_DROP} req_mode_t;

    typedef struct {
        string     name;
        kind_t     kind;
        int        len;
        int        quanta;
        int        er_pos;
        bit        corrupt_fcs;
        bit        lfc_en;
        bit        exp_bad;
        bit        exp_bad_frame;
        bit        exp_bad_fcs;
        req_mode_t req;
    } test_t;

    logic                   rx_clk = 1'b0;
    logic                   rx_rst;
    eth_rx_pkg::gmii_rx_t   gmii;
    logic                   rx_lfc_en;
    eth_rx_pkg::rx_beat_t   rx_axis;
    eth_rx_pkg::rx_status_t rx_status;
    logic                   rx_lfc_req;
    eth_rx_pkg::lfc_stat_t  stat_rx;

    test_t                  tests[$];
    eth_rx_pkg::byte_t      frame_q[$];
    eth_rx_pkg::rx_beat_t   beat_q[$];
    logic                   req_q[$];
    logic                   paused_q[$];
    eth_rx_pkg::rx_status_t last_status;
    eth_rx_pkg::lfc_stat_t  stat_seen;
    bit                     got_last;
    int                     n_start, n_bad_frame, n_bad_fcs, n_pkt;
    int                     cyc, err_total, test_errs, n_passed;

    always #(CLK_PERIOD / 2) rx_clk = ~rx_clk;

    eth_mac_rx dut_i (
        .rx_clk     (rx_clk),
        .rx_rst     (rx_rst),
        .gmii       (gmii),
        .rx_lfc_en  (rx_lfc_en),
        .rx_axis    (rx_axis),
        .rx_status  (rx_status),
        .rx_lfc_req (rx_lfc_req),
        .stat_rx    (stat_rx)
    );

    bind eth_mac_rx eth_mac_rx_checker checker_i (
        .rx_clk     (rx_clk),
        .rx_rst     (rx_rst),
        .rx_lfc_en  (rx_lfc_en),
        .rx_axis    (rx_axis),
        .rx_status  (rx_status),
        .mcf_valid  (mcf_valid),
        .rx_lfc_req (rx_lfc_req)
    );

    function automatic void fill_table();
        // Name, kind, payload bytes, quanta, er byte, corrupt FCS, lfc_en,
        // then expected bad, bad_frame, bad_fcs and request shape.
        tests.push_back('{"good_data_100", KIND_DATA, 100, 0, -1, 0, 1, 0, 0, 0, REQ_LOW});
        tests.push_back('{"bad_fcs", KIND_DATA, 80, 0, -1, 1, 1, 1, 0, 1, REQ_LOW});
        tests.push_back('{"gmii_er", KIND_DATA, 80, 0, 30, 0, 1, 1, 1, 0, REQ_LOW});
        tests.push_back('{"runt_pause", KIND_PAUSE, 36, 5, -1, 0, 1, 1, 1, 0, REQ_LOW});
        tests.push_back('{"pause_q3", KIND_PAUSE, 60, 3, -1, 0, 1, 0, 0, 0, REQ_PULSE});
        tests.push_back('{"pause_q200", KIND_PAUSE, 60, 200, -1, 0, 1, 0, 0, 0, REQ_RISE});
        tests.push_back('{"pause_q0", KIND_PAUSE, 60, 0, -1, 0, 1, 0, 0, 0, REQ_DROP});
        tests.push_back('{"pause_lfc_off", KIND_PAUSE, 60, 9, -1, 0, 0, 0, 0, 0, REQ_LOW});
    endfunction

    task automatic count_error();
        err_total++;
        test_errs++;
    endtask

    task automatic check_beat(string name, int idx, eth_rx_pkg::rx_beat_t exp,
                              eth_rx_pkg::rx_beat_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: beat %0d expected %p actual %p", name, idx, exp, act);
            count_error();
        end
    endtask

    task automatic check_status(string name, eth_rx_pkg::rx_status_t exp,
                                eth_rx_pkg::rx_status_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: status at last beat expected %p actual %p", name, exp, act);
            count_error();
        end
    endtask

    task automatic check_stat(string name, eth_rx_pkg::lfc_stat_t exp,
                              eth_rx_pkg::lfc_stat_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: PAUSE stats expected %p actual %p", name, exp, act);
            count_error();
        end
    endtask

    task automatic check_level(string name, string what, logic exp, logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: %s expected %b actual %b", name, what, exp, act);
            count_error();
        end
    endtask

    task automatic check_count(string name, string what, int exp, int act);
        if (act != exp) begin
            $display("CHECK FAILED %s: %s expected %0d actual %0d", name, what, exp, act);
            count_error();
        end
    endtask

    // One clock. Outputs are sampled on the falling edge, before new inputs go out.
    task automatic tick();
        @(negedge rx_clk);
        cyc++;
        if (rx_axis.valid) begin
            beat_q.push_back(rx_axis);
            if (rx_axis.last) begin
                got_last    = 1'b1;
                last_status = rx_status;
            end
        end
        n_start     += rx_status.start_packet;
        n_bad_frame += rx_status.error_bad_frame;
        n_bad_fcs   += rx_status.error_bad_fcs;
        n_pkt       += stat_rx.pkt;
        stat_seen    = eth_rx_pkg::lfc_stat_t'(stat_seen | stat_rx);
        req_q.push_back(rx_lfc_req);
        paused_q.push_back(stat_rx.paused);
    endtask

    function automatic eth_rx_pkg::byte_t pause_hdr_byte(int i, int quanta);
        logic [8*eth_rx_pkg::MCF_HDR_BYTES-1:0] hdr;
        hdr = {eth_rx_pkg::MCF_DST_ADDR, 48'h02000000000A, eth_rx_pkg::MCF_ETH_TYPE,
               eth_rx_pkg::LFC_OPCODE, 16'(quanta)};
        return hdr[8*(eth_rx_pkg::MCF_HDR_BYTES-1-i) +: 8];
    endfunction

    // Payload plus FCS, FCS sent LSB first.
    task automatic build_frame(test_t t);
        logic [31:0]       crc;
        eth_rx_pkg::byte_t b;
        frame_q.delete();
        for (int i = 0; i < t.len; i++) begin
            b = eth_rx_pkg::byte_t'($urandom());
            if (t.kind == KIND_PAUSE && i < eth_rx_pkg::MCF_HDR_BYTES) begin
                b = pause_hdr_byte(i, t.quanta);
            end
            frame_q.push_back(b);
        end
        crc = 32'hFFFFFFFF;
        foreach (frame_q[i]) begin
            crc = eth_rx_pkg::crc32_byte(crc, frame_q[i]);
        end
        crc = t.corrupt_fcs ? crc : ~crc;
        for (int i = 0; i < 4; i++) begin
            frame_q.push_back(crc[8*i +: 8]);
        end
    endtask

    task automatic send_frame(test_t t, output int dv_fall);
        for (int i = 0; i < 8; i++) begin
            tick();
            gmii.rxd = (i == 7) ? eth_rx_pkg::ETH_SFD_BYTE : eth_rx_pkg::ETH_PREAMBLE_BYTE;
            gmii.dv  = 1'b1;
            gmii.er  = 1'b0;
        end
        foreach (frame_q[i]) begin
            tick();
            gmii.rxd = frame_q[i];
            gmii.er  = (i == t.er_pos);
        end
        tick();
        gmii    = '0;
        dv_fall = cyc;
    endtask

    // The request follows the fall of dv by three cycles.
    function automatic logic expected_req(test_t t, int rel);
        case (t.req)
            REQ_PULSE: return rel >= 3 && rel < 3 + t.quanta * QUANTUM;
            REQ_RISE:  return rel >= 3;
            REQ_DROP:  return rel < 3;
            default:   return 1'b0;
        endcase
    endfunction

    task automatic run_test(test_t t);
        int                     dv_fall;
        int                     base;
        int                     end_rel;
        int                     rel;
        bit                     act_pause;
        bit                     diverged;
        eth_rx_pkg::rx_beat_t   exp_beat;
        eth_rx_pkg::rx_status_t exp_status;
        eth_rx_pkg::lfc_stat_t  exp_stat;
        test_errs = 0;
        beat_q.delete();
        req_q.delete();
        paused_q.delete();
        got_last    = 1'b0;
        last_status = '0;
        stat_seen   = '0;
        n_start     = 0;
        n_bad_frame = 0;
        n_bad_fcs   = 0;
        n_pkt       = 0;
        base        = cyc + 1;
        rx_lfc_en   = t.lfc_en;
        build_frame(t);
        send_frame(t, dv_fall);
        for (int i = 0; i < 8 && !got_last; i++) begin
            tick();
        end
        if (!got_last) begin
            $display("%s: no last beat came out within 8 cycles of the frame end", t.name);
            count_error();
        end
        end_rel = (t.req == REQ_PULSE) ? 3 + t.quanta * QUANTUM + 12 : 15;
        while (cyc - dv_fall < end_rel) begin
            tick();
        end

        check_count(t.name, "output beats", t.len, beat_q.size());
        foreach (beat_q[i]) begin
            if (i < t.len) begin
                exp_beat = '{valid: 1'b1, data: frame_q[i], last: i == t.len - 1,
                             bad: i == t.len - 1 && t.exp_bad};
                check_beat(t.name, i, exp_beat, beat_q[i]);
            end
        end
        exp_status = '{start_packet: 1'b0, error_bad_frame: t.exp_bad_frame,
                       error_bad_fcs: t.exp_bad_fcs};
        check_status(t.name, exp_status, last_status);
        check_count(t.name, "start_packet pulses", 1, n_start);
        check_count(t.name, "error_bad_frame pulses", t.exp_bad_frame, n_bad_frame);
        check_count(t.name, "error_bad_fcs pulses", t.exp_bad_fcs, n_bad_fcs);

        // Only a good PAUSE frame with flow control on acts.
        act_pause = t.kind == KIND_PAUSE && !t.exp_bad && t.lfc_en;
        exp_stat  = '{pkt: act_pause, xon: act_pause && t.quanta == 0,
                      xoff: act_pause && t.quanta != 0, paused: t.req != REQ_LOW};
        check_stat(t.name, exp_stat, stat_seen);
        check_count(t.name, "pkt pulses", int'(act_pause), n_pkt);
        diverged = 1'b0;
        foreach (req_q[j]) begin
            rel = base + j - dv_fall;
            if (!diverged && (req_q[j] !== expected_req(t, rel) || paused_q[j] !== req_q[j])) begin
                diverged = 1'b1;
                check_level(t.name, $sformatf("rx_lfc_req %0d cycles after dv fell", rel),
                            expected_req(t, rel), req_q[j]);
                check_level(t.name, "stat paused against rx_lfc_req", req_q[j], paused_q[j]);
            end
        end
    endtask

    task automatic stop_on_timeout(longint cycles);
        #(cycles * CLK_PERIOD);
        $display("Watchdog: the run did not finish within %0d clock cycles", cycles);
        $display("Test failed");
        $finish;
    endtask

    initial begin
        longint limit;
        // Fixed seed for repeatable payloads.
        void'($urandom(414));
        rx_rst    = 1'b1;
        gmii      = '0;
        rx_lfc_en = 1'b0;
        cyc       = 0;
        err_total = 0;
        n_passed  = 0;
        fill_table();
        limit = 8 + 16;
        foreach (tests[i]) begin
            limit += 2 * (12 + tests[i].len + 20 + tests[i].quanta * QUANTUM);
        end
        fork
            stop_on_timeout(limit);
        join_none

        repeat (8) @(posedge rx_clk);
        @(negedge rx_clk);
        rx_rst = 1'b0;
        repeat (16) tick();
        foreach (tests[i]) begin
            run_test(tests[i]);
            if (test_errs == 0) begin
                n_passed++;
            end
            $display("%s %s (%0d errors)", test_errs == 0 ? "PASS" : "FAIL", tests[i].name,
                     test_errs);
        end
        $display("Tests run %0d, passed %0d, check errors %0d, assertion errors %0d",
                 tests.size(), n_passed, err_total, dut_i.checker_i.fail_cnt);
        if (err_total == 0 && dut_i.checker_i.fail_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
